// ==== common/fpga_rt_params.svh ====
/* Realtime debug register block parameters
   FIFO depths, register map and field positions */
`ifndef FPGA_RT_PARAMS_SVH
`define FPGA_RT_PARAMS_SVH

// FIFO sizes, log depth doubles as the producer's initial credit count
`define RT_LOG_DEPTH        16
`define RT_ENT_DEPTH        4

// Register word addresses
`define RT_ADDR_CONTROL     4'h0
`define RT_ADDR_STATUS      4'h1
`define RT_ADDR_LOG_DATA    4'h2
`define RT_ADDR_ENT_DATA    4'h3
`define RT_ADDR_DIVISOR     4'h4
`define RT_ADDR_CYCLES      4'h5

// STATUS fields
`define RT_ST_LOG_EMPTY     0
`define RT_ST_LOG_FULL      1
`define RT_ST_ENT_EMPTY     2
`define RT_ST_ENT_FULL      3

// Field positions in LOG_DATA and CONTROL
`define RT_LOG_VALID_BIT    8
`define RT_CTRL_ENT_FLUSH   0

`endif

// ==== common/fpga_rt_pkg.sv ====
/* Realtime debug register block types
   Shared widths for the host bus, log characters, entropy nibbles and counters */
`default_nettype none

package fpga_rt_pkg;

    // Host register bus
    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One log character from the core side
    typedef logic [7:0]  char_t;

    // Entropy is handed to the core one nibble at a time
    typedef logic [3:0]  nibble_t;

    // Free-running cycle counter, also used for the throttle divisor
    typedef logic [31:0] count_t;

endpackage

`default_nettype wire

// ==== logic/rt_reg_ctrl.sv ====
/* Register access for the realtime debug block
   Decodes host reads and writes, holds control, divisor and cycle counter */
`timescale 1ns/1ns
`default_nettype none

`include "fpga_rt_params.svh"

module rt_reg_ctrl (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  reg_wr,
    input  logic                  reg_rd,
    input  fpga_rt_pkg::reg_addr_t reg_addr,
    input  fpga_rt_pkg::reg_data_t reg_wdata,
    input  fpga_rt_pkg::char_t     log_head,
    input  logic                  log_empty,
    input  logic                  log_full,
    input  logic                  ent_empty,
    input  logic                  ent_full,
    output fpga_rt_pkg::reg_data_t reg_rdata,
    output logic                  reg_rvalid,
    output logic                  log_pop,
    output logic                  ent_push,
    output fpga_rt_pkg::reg_data_t ent_word,
    output logic                  ent_flush,
    output fpga_rt_pkg::count_t    divisor
);

    import fpga_rt_pkg::*;

    reg_data_t ctrl_q;
    count_t    divisor_q;
    count_t    cycle_q;
    reg_data_t rd_next;

    logic      wr_ctrl;
    logic      wr_div;
    logic      rd_log;

    assign wr_ctrl = reg_wr && (reg_addr == `RT_ADDR_CONTROL);
    assign wr_div  = reg_wr && (reg_addr == `RT_ADDR_DIVISOR);
    assign rd_log  = reg_rd && (reg_addr == `RT_ADDR_LOG_DATA);

    // Pop only when the read finds an entry, same empty flag as the valid bit
    assign log_pop   = rd_log && !log_empty;

    // ENT_DATA writes go straight to the FIFO, which drops them when full
    assign ent_push  = reg_wr && (reg_addr == `RT_ADDR_ENT_DATA);
    assign ent_word  = reg_wdata;

    assign ent_flush = ctrl_q[`RT_CTRL_ENT_FLUSH];
    assign divisor   = divisor_q;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            ctrl_q    <= '0;
            divisor_q <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl_q <= reg_wdata;
            end
            if (wr_div) begin
                divisor_q <= reg_wdata;
            end
        end
    end

    // Free-running cycle counter
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    // Read mux, unused and write-only addresses return zero
    always_comb begin
        rd_next = '0;
        case (reg_addr)
            `RT_ADDR_CONTROL: begin
                rd_next = ctrl_q;
            end
            `RT_ADDR_STATUS: begin
                rd_next[`RT_ST_LOG_EMPTY] = log_empty;
                rd_next[`RT_ST_LOG_FULL]  = log_full;
                rd_next[`RT_ST_ENT_EMPTY] = ent_empty;
                rd_next[`RT_ST_ENT_FULL]  = ent_full;
            end
            `RT_ADDR_LOG_DATA: begin
                if (!log_empty) begin
                    rd_next[`RT_LOG_VALID_BIT]     = 1'b1;
                    rd_next[$bits(char_t)-1:0] = log_head;
                end
            end
            `RT_ADDR_DIVISOR: begin
                rd_next = divisor_q;
            end
            `RT_ADDR_CYCLES: begin
                rd_next = cycle_q;
            end
            default: begin
                rd_next = '0;
            end
        endcase
    end

    // Read data lands one cycle after reg_rd
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_next;
        end
    end

endmodule

`default_nettype wire

// ==== log_fifo/log_fifo.sv ====
/* Log character FIFO, first word fall through
   Each pop hands one credit back to the core-side producer */
`timescale 1ns/1ns
`default_nettype none

`include "fpga_rt_params.svh"

module log_fifo (
    input  logic              core_clk,
    input  logic              hwif_out,
    input  logic              log_wr,
    input  fpga_rt_pkg::char_t log_char,
    input  logic              log_pop,
    output fpga_rt_pkg::char_t log_head,
    output logic              log_empty,
    output logic              log_full,
    output logic              log_credit
);

    import fpga_rt_pkg::*;

    localparam int PTR_W = $clog2(`RT_LOG_DEPTH);
    localparam logic [PTR_W:0] DEPTH_C = `RT_LOG_DEPTH;

    char_t             mem [0:`RT_LOG_DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;

    logic              wr_en;
    logic              rd_en;

    assign log_empty = (count == '0);
    assign log_full  = (count == DEPTH_C);

    // Writes without room are lost, the producer should have held a credit
    assign wr_en = log_wr && !log_full;
    assign rd_en = log_pop && !log_empty;

    assign log_head = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= log_char;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // One credit pulse per pop, a cycle later
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            log_credit <= 1'b0;
        end else begin
            log_credit <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== entropy/entropy_fifo.sv ====
/* Entropy FIFO, 32-bit words in and nibbles out
   Low nibble first, head word retires after its last nibble */
`timescale 1ns/1ns
`default_nettype none

`include "fpga_rt_params.svh"

module entropy_fifo (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  ent_push,
    input  fpga_rt_pkg::reg_data_t ent_word,
    input  logic                  ent_flush,
    input  logic                  ent_grant,
    output logic                  ent_empty,
    output logic                  ent_full,
    output fpga_rt_pkg::nibble_t   itrng_data,
    output logic                  itrng_valid
);

    import fpga_rt_pkg::*;

    localparam int PTR_W   = $clog2(`RT_ENT_DEPTH);
    localparam int NIB_W   = $bits(nibble_t);
    localparam int NIB_CNT = $bits(reg_data_t) / NIB_W;
    localparam int IDX_W   = $clog2(NIB_CNT);
    localparam logic [PTR_W:0] DEPTH_C  = `RT_ENT_DEPTH;
    localparam logic [IDX_W-1:0] LAST_NIB = IDX_W'(NIB_CNT - 1);

    reg_data_t         mem [0:`RT_ENT_DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic [IDX_W-1:0]  nib_idx;

    logic              push_ok;
    logic              grant_ok;
    logic              retire;

    assign ent_empty = (count == '0);
    assign ent_full  = (count == DEPTH_C);

    // Flush wins over both push and grant
    assign push_ok  = ent_push && !ent_full && !ent_flush;
    assign grant_ok = ent_grant && !ent_empty && !ent_flush;
    assign retire   = grant_ok && (nib_idx == LAST_NIB);

    always_ff @(posedge core_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= ent_word;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else if (ent_flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (grant_ok) begin
                nib_idx <= nib_idx + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // Nibble goes out the cycle after its grant
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= grant_ok;
        end
    end

    always_ff @(posedge core_clk) begin
        if (grant_ok) begin
            itrng_data <= mem[rd_ptr][nib_idx*NIB_W +: NIB_W];
        end
    end

endmodule

`default_nettype wire

// ==== entropy/entropy_throttle.sv ====
/* Entropy request throttle
   Passes at most one request per divisor+1 cycles */
`timescale 1ns/1ns
`default_nettype none

module entropy_throttle (
    input  logic               core_clk,
    input  logic               hwif_out,
    input  logic               etrng_req,
    input  fpga_rt_pkg::count_t divisor,
    output logic               ent_grant
);

    import fpga_rt_pkg::*;

    count_t countdown;

    // Sample the request at zero and reload, otherwise just count down
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            countdown <= '0;
            ent_grant <= 1'b0;
        end else if (countdown == '0) begin
            ent_grant <= etrng_req;
            countdown <= divisor;
        end else begin
            ent_grant <= 1'b0;
            countdown <= countdown - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fpga_rt_top.sv ====
/* Realtime debug register block top level
   Register access plus log FIFO, entropy FIFO and request throttle */
`timescale 1ns/1ns
`default_nettype none

module fpga_rt_top (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  reg_wr,
    input  logic                  reg_rd,
    input  fpga_rt_pkg::reg_addr_t reg_addr,
    input  fpga_rt_pkg::reg_data_t reg_wdata,
    input  logic                  log_wr,
    input  fpga_rt_pkg::char_t     log_char,
    input  logic                  etrng_req,
    output fpga_rt_pkg::reg_data_t reg_rdata,
    output logic                  reg_rvalid,
    output logic                  log_credit,
    output fpga_rt_pkg::nibble_t   itrng_data,
    output logic                  itrng_valid
);

    import fpga_rt_pkg::*;

    // Log path
    char_t     log_head;
    logic      log_empty;
    logic      log_full;
    logic      log_pop;

    // Entropy path
    reg_data_t ent_word;
    logic      ent_push;
    logic      ent_flush;
    logic      ent_empty;
    logic      ent_full;
    logic      ent_grant;
    count_t    divisor;

    rt_reg_ctrl u_reg_ctrl (
        .core_clk   (core_clk),
        .hwif_out   (hwif_out),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .log_head   (log_head),
        .log_empty  (log_empty),
        .log_full   (log_full),
        .ent_empty  (ent_empty),
        .ent_full   (ent_full),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .log_pop    (log_pop),
        .ent_push   (ent_push),
        .ent_word   (ent_word),
        .ent_flush  (ent_flush),
        .divisor    (divisor)
    );

    log_fifo u_log_fifo (
        .core_clk   (core_clk),
        .hwif_out   (hwif_out),
        .log_wr     (log_wr),
        .log_char   (log_char),
        .log_pop    (log_pop),
        .log_head   (log_head),
        .log_empty  (log_empty),
        .log_full   (log_full),
        .log_credit (log_credit)
    );

    entropy_fifo u_entropy_fifo (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .ent_push    (ent_push),
        .ent_word    (ent_word),
        .ent_flush   (ent_flush),
        .ent_grant   (ent_grant),
        .ent_empty   (ent_empty),
        .ent_full    (ent_full),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    entropy_throttle u_entropy_throttle (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .etrng_req (etrng_req),
        .divisor   (divisor),
        .ent_grant (ent_grant)
    );

endmodule

`default_nettype wire

// ==== test/rt_clk_gen.sv ====
/* Testbench clock and reset source
   40 ns core clock, active-low reset held for the first 5 cycles */
`timescale 1ns/1ns
`default_nettype none

module rt_clk_gen (
    output logic core_clk,
    output logic hwif_out
);

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    // Release away from the rising edge
    initial begin
        hwif_out = 1'b0;
        repeat (5) @(posedge core_clk);
        @(negedge core_clk);
        hwif_out = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/rt_checker.sv ====
/* Bound assertions for the realtime debug block
   Read timing, log credit use and entropy pulse spacing */
`timescale 1ns/1ns
`default_nettype none

`include "fpga_rt_params.svh"

module rt_checker (
    input logic                core_clk,
    input logic                hwif_out,
    input logic                reg_rd,
    input logic                reg_rvalid,
    input logic                log_wr,
    input logic                log_credit,
    input logic                itrng_valid,
    input fpga_rt_pkg::count_t divisor
);

    import fpga_rt_pkg::*;

    int     credits_q;
    count_t since_q;
    int     fail_count = 0;

    // Producer credits as seen from the bus
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            credits_q <= `RT_LOG_DEPTH;
        end else begin
            credits_q <= credits_q + int'(log_credit) - int'(log_wr);
        end
    end

    // Cycles since the last itrng_valid, saturating
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            since_q <= '1;
        end else if (itrng_valid) begin
            since_q <= '0;
        end else if (since_q != '1) begin
            since_q <= since_q + 1'b1;
        end
    end

    rvalid_after_rd: assert property (@(posedge core_clk) disable iff (!hwif_out)
        reg_rd |=> reg_rvalid)
    else begin
        fail_count++;
        $error("reg_rvalid did not follow reg_rd");
    end

    no_rvalid_without_rd: assert property (@(posedge core_clk) disable iff (!hwif_out)
        !reg_rd |=> !reg_rvalid)
    else begin
        fail_count++;
        $error("reg_rvalid without a read one cycle earlier");
    end

    // A credit arriving in the same cycle may be spent at once
    log_wr_has_credit: assert property (@(posedge core_clk) disable iff (!hwif_out)
        log_wr |-> (credits_q > 0 || log_credit))
    else begin
        fail_count++;
        $error("log_wr with no credit left");
    end

    itrng_spacing: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> (since_q >= divisor))
    else begin
        fail_count++;
        $error("itrng_valid pulses closer than divisor+1 cycles");
    end

endmodule

`default_nettype wire

// ==== test/rt_tb.sv ====
/* Testbench for the realtime debug register block
   Random log and entropy traffic checked against a queue model */
`timescale 1ns/1ns
`default_nettype none

`include "fpga_rt_params.svh"

module rt_tb;

    import fpga_rt_pkg::*;

    localparam int LOG_OPS = 400;
    localparam int MAX_DIV = 5;
    localparam int TIMEOUT_CYCLES =
        2 * (LOG_OPS + 4 * `RT_LOG_DEPTH + 8 * `RT_ENT_DEPTH * (MAX_DIV + 2)) + 200;

    logic      core_clk;
    logic      hwif_out;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    logic      log_wr;
    char_t     log_char;
    logic      etrng_req;
    reg_data_t reg_rdata;
    logic      reg_rvalid;
    logic      log_credit;
    nibble_t   itrng_data;
    logic      itrng_valid;

    // Model state
    char_t     log_q[$];
    nibble_t   nib_q[$];
    int        credits;
    int        exp_div;
    int        errors;
    int        cycles;
    bit        seen_valid;
    int        last_valid;

    rt_clk_gen u_clk_gen (
        .core_clk (core_clk),
        .hwif_out (hwif_out)
    );

    fpga_rt_top UUT (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .log_wr      (log_wr),
        .log_char    (log_char),
        .etrng_req   (etrng_req),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .log_credit  (log_credit),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

    bind fpga_rt_top rt_checker u_rt_checker (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .reg_rd      (reg_rd),
        .reg_rvalid  (reg_rvalid),
        .log_wr      (log_wr),
        .log_credit  (log_credit),
        .itrng_valid (itrng_valid),
        .divisor     (divisor)
    );

    task automatic report_mismatch(input string name, input reg_data_t exp,
                                   input reg_data_t act);
        errors++;
        $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    endtask

    function automatic reg_data_t expected_status();
        reg_data_t st;
        st = '0;
        st[`RT_ST_LOG_EMPTY] = (log_q.size() == 0);
        st[`RT_ST_LOG_FULL]  = (log_q.size() == `RT_LOG_DEPTH);
        st[`RT_ST_ENT_EMPTY] = (nib_q.size() == 0);
        st[`RT_ST_ENT_FULL]  = ((nib_q.size() + 7) / 8 == `RT_ENT_DEPTH);
        return st;
    endfunction

    // Advance to the next falling edge and collect credits and nibbles
    task automatic next_cycle();
        nibble_t exp_nib;
        @(negedge core_clk);
        if (log_credit) begin
            credits++;
        end
        if (itrng_valid) begin
            if (nib_q.size() == 0) begin
                errors++;
                $display("itrng_valid high with no entropy expected at cycle %0d", cycles);
            end else begin
                exp_nib = nib_q.pop_front();
                if (itrng_data !== exp_nib) begin
                    report_mismatch("entropy order", reg_data_t'(exp_nib),
                                    reg_data_t'(itrng_data));
                end
            end
            if (seen_valid && (cycles - last_valid) < exp_div + 1) begin
                errors++;
                $display("itrng_valid pulses %0d cycles apart with divisor %0d",
                         cycles - last_valid, exp_div);
            end
            seen_valid = 1'b1;
            last_valid = cycles;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        next_cycle();
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        next_cycle();
        reg_rd   = 1'b0;
        if (!reg_rvalid) begin
            errors++;
            $display("reg_rvalid missing one cycle after a read of address %0h", addr);
        end
        data = reg_rdata;
    endtask

    task automatic push_entropy(input reg_data_t word);
        int n;
        if ((nib_q.size() + 7) / 8 < `RT_ENT_DEPTH) begin
            for (n = 0; n < 8; n++) begin
                nib_q.push_back(word[n*4 +: 4]);
            end
        end
        write_reg(`RT_ADDR_ENT_DATA, word);
    endtask

    // Let the throttle reload before any new entropy flows
    task automatic set_divisor(input int new_div);
        int old_div;
        old_div = exp_div;
        write_reg(`RT_ADDR_DIVISOR, reg_data_t'(new_div));
        exp_div = new_div;
        repeat (old_div + new_div + 4) next_cycle();
    endtask

    task automatic drain_log();
        reg_data_t exp_data;
        reg_data_t rdata;
        while (log_q.size() > 0) begin
            exp_data = '0;
            exp_data[`RT_LOG_VALID_BIT] = 1'b1;
            exp_data[7:0] = log_q.pop_front();
            read_reg(`RT_ADDR_LOG_DATA, rdata);
            if (rdata !== exp_data) begin
                report_mismatch("log drain", exp_data, rdata);
            end
        end
        read_reg(`RT_ADDR_LOG_DATA, rdata);
        if (rdata !== '0) begin
            report_mismatch("empty log read", '0, rdata);
        end
        repeat (2) next_cycle();
        if (credits != `RT_LOG_DEPTH) begin
            report_mismatch("credits after drain", `RT_LOG_DEPTH, reg_data_t'(credits));
        end
    endtask

    // Cycle limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge core_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d errors", cycles, errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int        i;
        int        k;
        int        d;
        bit        do_wr;
        bit        do_rd;
        reg_data_t exp_data;
        reg_data_t rdata;
        reg_data_t first;

        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        log_wr     = 1'b0;
        log_char   = '0;
        etrng_req  = 1'b0;
        errors     = 0;
        credits    = `RT_LOG_DEPTH;
        exp_div    = 0;
        seen_valid = 1'b0;
        last_valid = 0;
        void'($urandom(32'h1e25));

        @(posedge hwif_out);
        next_cycle();

        // Reset values and readback
        read_reg(`RT_ADDR_STATUS, rdata);
        if (rdata !== expected_status()) begin
            report_mismatch("reset status", expected_status(), rdata);
        end
        read_reg(`RT_ADDR_DIVISOR, rdata);
        if (rdata !== '0) begin
            report_mismatch("reset divisor", '0, rdata);
        end
        read_reg(`RT_ADDR_CONTROL, rdata);
        if (rdata !== '0) begin
            report_mismatch("reset control", '0, rdata);
        end
        d = $urandom_range(2, 9);
        set_divisor(d);
        read_reg(`RT_ADDR_DIVISOR, rdata);
        if (rdata !== reg_data_t'(d)) begin
            report_mismatch("divisor readback", reg_data_t'(d), rdata);
        end
        exp_data = $urandom & ~32'h1;
        write_reg(`RT_ADDR_CONTROL, exp_data);
        read_reg(`RT_ADDR_CONTROL, rdata);
        if (rdata !== exp_data) begin
            report_mismatch("control readback", exp_data, rdata);
        end
        write_reg(`RT_ADDR_CONTROL, '0);
        set_divisor(0);

        // Random producer with credits against random host reads
        for (i = 0; i < LOG_OPS; i++) begin
            do_wr    = (credits > 0) && ($urandom_range(0, 2) != 0);
            do_rd    = ($urandom_range(0, 1) == 0);
            log_wr   = do_wr;
            log_char = char_t'($urandom);
            reg_rd   = do_rd;
            reg_addr = `RT_ADDR_LOG_DATA;
            exp_data = '0;
            if (do_rd && log_q.size() > 0) begin
                exp_data[`RT_LOG_VALID_BIT] = 1'b1;
                exp_data[7:0] = log_q.pop_front();
            end
            if (do_wr) begin
                credits--;
                log_q.push_back(log_char);
            end
            next_cycle();
            log_wr = 1'b0;
            reg_rd = 1'b0;
            if (credits + log_q.size() > `RT_LOG_DEPTH) begin
                errors++;
                $display("Producer holds more credits than free log entries at cycle %0d",
                         cycles);
            end
            if (do_rd && reg_rdata !== exp_data) begin
                report_mismatch("log read", exp_data, reg_rdata);
            end
        end
        drain_log();

        // Fill the log FIFO with no reads
        for (i = 0; i < `RT_LOG_DEPTH; i++) begin
            log_wr   = 1'b1;
            log_char = char_t'($urandom);
            credits--;
            log_q.push_back(log_char);
            next_cycle();
        end
        log_wr = 1'b0;
        read_reg(`RT_ADDR_STATUS, rdata);
        if (rdata !== expected_status()) begin
            report_mismatch("log full status", expected_status(), rdata);
        end
        if (credits != 0) begin
            report_mismatch("credits when full", '0, reg_data_t'(credits));
        end
        drain_log();

        // Entropy order with pushes past full
        for (i = 0; i < `RT_ENT_DEPTH + 2; i++) begin
            push_entropy($urandom);
        end
        read_reg(`RT_ADDR_STATUS, rdata);
        if (rdata !== expected_status()) begin
            report_mismatch("entropy full status", expected_status(), rdata);
        end
        etrng_req = 1'b1;
        while (nib_q.size() > 0) begin
            next_cycle();
        end
        etrng_req = 1'b0;
        repeat (4) next_cycle();
        read_reg(`RT_ADDR_STATUS, rdata);
        if (rdata !== expected_status()) begin
            report_mismatch("entropy drained status", expected_status(), rdata);
        end

        // Throttled draw
        d = $urandom_range(1, MAX_DIV);
        set_divisor(d);
        read_reg(`RT_ADDR_DIVISOR, rdata);
        if (rdata !== reg_data_t'(d)) begin
            report_mismatch("throttle divisor", reg_data_t'(d), rdata);
        end
        push_entropy($urandom);
        push_entropy($urandom);
        etrng_req = 1'b1;
        while (nib_q.size() > 0) begin
            next_cycle();
        end
        etrng_req = 1'b0;
        repeat (d + 4) next_cycle();

        // Flush drops stored words and nothing comes out afterwards
        push_entropy($urandom);
        push_entropy($urandom);
        write_reg(`RT_ADDR_CONTROL, 32'h1);
        nib_q.delete();
        next_cycle();
        read_reg(`RT_ADDR_STATUS, rdata);
        if (rdata !== expected_status()) begin
            report_mismatch("flush status", expected_status(), rdata);
        end
        write_reg(`RT_ADDR_CONTROL, '0);
        etrng_req = 1'b1;
        repeat (4 * (d + 1) + 4) next_cycle();
        etrng_req = 1'b0;
        push_entropy($urandom);
        etrng_req = 1'b1;
        while (nib_q.size() > 0) begin
            next_cycle();
        end
        etrng_req = 1'b0;
        repeat (d + 4) next_cycle();

        // Two counter reads k cycles apart
        k = $urandom_range(2, 20);
        read_reg(`RT_ADDR_CYCLES, first);
        repeat (k - 1) next_cycle();
        read_reg(`RT_ADDR_CYCLES, rdata);
        if (rdata - first !== reg_data_t'(k)) begin
            report_mismatch("cycle counter delta", reg_data_t'(k), rdata - first);
        end

        $display("Done: %0d check errors, %0d assertion failures",
                 errors, UUT.u_rt_checker.fail_count);
        if (errors == 0 && UUT.u_rt_checker.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fpga_rt.f ====
+incdir+common
common/fpga_rt_pkg.sv
logic/rt_reg_ctrl.sv
log_fifo/log_fifo.sv
entropy/entropy_fifo.sv
entropy/entropy_throttle.sv
logic/fpga_rt_top.sv
test/rt_clk_gen.sv
test/rt_checker.sv
test/rt_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log for a pass
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f fpga_rt.f --top-module rt_tb -o rt_sim

# Keep running after an assertion error so the testbench prints its report
./obj_dir/rt_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
